/* idct_block_buffer.sv */
/*
  On-chip storage for one block: the S' bank from the input stream and the T bank.
  T is kept column-major so a second-pass quad is four consecutive words.
*/
`timescale 1ns/1ps

module idct_block_buffer import idct_pkg::*; (
	input logic Clock_50,
	input logic resetn,
	input logic advance,
	input logic in_valid_beat,
	input coef_t in_data,
	input idx_t load_row,
	input idx_t load_col,
	idct_buf_if.store buf_if
);

	prod_t s_bank [BLOCK_WORDS];
	prod_t t_bank [BLOCK_WORDS];
	addr_t rd_base;

	// S'[row][4h..] in the first pass, T[4h..][col] in the second
	always_comb begin
		if (buf_if.rd_pass == PASS_ROW)
			rd_base = {buf_if.rd_row, buf_if.rd_half, 2'b00};
		else
			rd_base = {buf_if.rd_col, buf_if.rd_half, 2'b00};
	end

	always_ff @(posedge Clock_50) begin
		if (in_valid_beat)
			s_bank[{load_row, load_col}] <= prod_t'(in_data);
		if (buf_if.wr_en)
			t_bank[{buf_if.wr_col, buf_if.wr_row}] <= buf_if.wr_data;
	end

	// Quad is registered and holds while the pipeline is frozen
	always_ff @(posedge Clock_50) begin
		if (advance) begin
			for (int j = 0; j < 4; j++) begin
				if (buf_if.rd_pass == PASS_ROW)
					buf_if.rd_quad[j] <= s_bank[rd_base + addr_t'(j)];
				else
					buf_if.rd_quad[j] <= t_bank[rd_base + addr_t'(j)];
			end
		end
	end

	// All T writes must land before the second pass starts reading
	a_no_t_write_in_col: assert property (
		@(posedge Clock_50) disable iff (!resetn)
		buf_if.wr_en |-> (buf_if.rd_pass == PASS_ROW)
	) else $error("T write while second pass reads are active");

endmodule

/* idct_buf_if.sv */
/*
  Read and write bundle of the block buffer.
  The step counter issues read indices, the MAC consumes the quad and writes T back.
*/
`timescale 1ns/1ps

interface idct_buf_if import idct_pkg::*; ();

	// Read request and registered four-word result
	pass_t rd_pass;
	idx_t rd_row;
	idx_t rd_col;
	logic rd_half;
	prod_t [3:0] rd_quad;

	// T write-back from the first pass
	logic wr_en;
	idx_t wr_row;
	idx_t wr_col;
	prod_t wr_data;

	modport store (
		input rd_pass, rd_row, rd_col, rd_half,
		input wr_en, wr_row, wr_col, wr_data,
		output rd_quad
	);

	modport reader (
		output rd_pass, rd_row, rd_col, rd_half
	);

	modport arith (
		input rd_pass, rd_row, rd_col, rd_half, rd_quad,
		output wr_en, wr_row, wr_col, wr_data
	);

endinterface

/* idct_ctrl.sv */
/*
  Phase FSM of the IDCT engine.
  Owns the input and output handshakes and freezes the pipeline under back-pressure.
*/
`timescale 1ns/1ps

module idct_ctrl import idct_pkg::*; (
	input logic Clock_50,
	input logic resetn,
	input logic in_valid,
	output logic in_ready,
	input logic out_ready,
	output logic out_valid,
	input logic res_valid,
	input logic phase_done,
	output ctrl_state_t phase,
	output logic advance
);

	ctrl_state_t state;
	logic last_issued;

	assign phase = state;
	assign in_ready = (state == ST_LOAD);

	// Results only count as pixels in the second pass
	assign out_valid = (state == ST_PASS2) && res_valid;

	always_comb begin
		case (state)
			ST_LOAD: advance = in_valid;
			ST_PASS2: advance = !(out_valid && !out_ready);
			default: advance = 1'b1;
		endcase
	end

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			state <= ST_LOAD;
			last_issued <= 1'b0;
		end else begin
			case (state)
				ST_LOAD: begin
					if (phase_done)
						state <= ST_PASS1;
				end
				ST_PASS1: begin
					if (phase_done)
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					if (phase_done)
						state <= ST_PASS2;
				end
				ST_PASS2: begin
					// Once the last index is out, the next accepted pixel ends the block
					if (phase_done)
						last_issued <= 1'b1;
					if (last_issued && out_valid && out_ready) begin
						last_issued <= 1'b0;
						state <= ST_LOAD;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	// A stalled pixel must stay offered until taken
	a_out_valid_hold: assert property (
		@(posedge Clock_50) disable iff (!resetn)
		(out_valid && !out_ready) |=> out_valid
	) else $error("out_valid dropped while out_ready was low");

endmodule

/* idct_mac.sv */
/*
  Four-multiplier MAC shared by both IDCT passes.
  Sums two half quads per entry, scales per pass, writes T or emits a clipped pixel.
*/
`timescale 1ns/1ps

module idct_mac import idct_pkg::*; #(
	parameter int ROW_SHIFT = ROW_SHIFT_DEF,
	parameter int COL_SHIFT = COL_SHIFT_DEF
) (
	input logic Clock_50,
	input logic resetn,
	input logic advance,
	idct_buf_if.arith buf_if,
	output logic res_valid,
	output pixel_t out_data
);

	// Request fields delayed to line up with the registered quad
	pass_t q_pass;
	logic q_half;
	idx_t q_row;
	idx_t q_col;

	prod_t acc;
	prod_t [3:0] prod;
	prod_t quad_sum;
	prod_t total;
	prod_t shifted;
	pixel_t clipped;
	idx_t c_sel;

	// C[4h+j][col] for T = S'C, C[4h+j][row] for S = C'T
	assign c_sel = (q_pass == PASS_ROW) ? q_col : q_row;

	always_comb begin
		for (int j = 0; j < 4; j++)
			prod[j] = buf_if.rd_quad[j] * prod_t'(IDCT_C[{q_half, 2'(j)}][c_sel]);
	end

	assign quad_sum = prod[0] + prod[1] + prod[2] + prod[3];

	// acc holds the half 0 sum when half 1 is on the multipliers
	assign total = acc + quad_sum;
	assign shifted = total >>> ((q_pass == PASS_ROW) ? ROW_SHIFT : COL_SHIFT);

	always_comb begin
		if (shifted < 0)
			clipped = '0;
		else if (shifted > 255)
			clipped = 8'd255;
		else
			clipped = shifted[7:0];
	end

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			q_pass <= PASS_ROW;
			q_half <= 1'b0;
			buf_if.wr_en <= 1'b0;
			res_valid <= 1'b0;
		end else if (advance) begin
			q_pass <= buf_if.rd_pass;
			q_half <= buf_if.rd_half;
			buf_if.wr_en <= q_half && (q_pass == PASS_ROW);
			res_valid <= q_half && (q_pass == PASS_COL);
		end
	end

	always_ff @(posedge Clock_50) begin
		if (advance) begin
			q_row <= buf_if.rd_row;
			q_col <= buf_if.rd_col;
			acc <= quad_sum;
			buf_if.wr_row <= q_row;
			buf_if.wr_col <= q_col;
			buf_if.wr_data <= shifted;
			// Pixel stays put until the next one is finished
			if (q_half && (q_pass == PASS_COL))
				out_data <= clipped;
		end
	end

endmodule

/* idct_pkg.sv */
/*
  Shared widths, types, state encodings and the fixed-point IDCT coefficient table.
  Imported by every RTL block of the 8x8 inverse DCT engine and by its testbench.
*/
package idct_pkg;

	// Block geometry
	localparam int BLOCK_N = 8;
	localparam int BLOCK_WORDS = 64;

	// Default per-pass scaling, 4096 x 4096 total gain
	localparam int ROW_SHIFT_DEF = 8;
	localparam int COL_SHIFT_DEF = 16;

	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] prod_t;
	typedef logic [7:0] pixel_t;
	typedef logic [2:0] idx_t;
	typedef logic [5:0] addr_t;

	typedef enum logic {
		PASS_ROW,
		PASS_COL
	} pass_t;

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_PASS1,
		ST_DRAIN,
		ST_PASS2
	} ctrl_state_t;

	// C[k][n] = c(k) * cos((2n+1)k*pi/16) * 4096
	localparam coef_t IDCT_C [BLOCK_N][BLOCK_N] = '{
		'{1448, 1448, 1448, 1448, 1448, 1448, 1448, 1448},
		'{2009, 1703, 1138, 400, -400, -1138, -1703, -2009},
		'{1892, 784, -784, -1892, -1892, -784, 784, 1892},
		'{1703, -400, -2009, -1138, 1138, 2009, 400, -1703},
		'{1448, -1448, -1448, 1448, 1448, -1448, -1448, 1448},
		'{1138, -2009, 400, 1703, -1703, -400, 2009, -1138},
		'{784, -1892, 1892, -784, -784, 1892, -1892, 784},
		'{400, -1138, 1703, -2009, 2009, -1703, 1138, -400}
	};

endpackage

/* idct_step_counter.sv */
/*
  Index walker for the IDCT phases.
  Steps (row, col) while loading and (row, col, half) in both passes, times the drain.
*/
`timescale 1ns/1ps

module idct_step_counter import idct_pkg::*; (
	input logic Clock_50,
	input logic resetn,
	input ctrl_state_t phase,
	input logic advance,
	idct_buf_if.reader buf_if,
	output idx_t load_row,
	output idx_t load_col,
	output logic phase_done
);

	localparam int DRAIN_CYCLES = 3;
	localparam idx_t LAST_IDX = idx_t'(BLOCK_N - 1);

	idx_t row;
	idx_t col;
	logic half;
	logic stopped;
	logic [1:0] drain_cnt;
	logic last_idx;
	logic walking;

	assign last_idx = (row == LAST_IDX) && (col == LAST_IDX);

	// Second pass parks after its last index until the block is drained
	assign walking = (phase == ST_PASS1) || ((phase == ST_PASS2) && !stopped);

	always_comb begin
		case (phase)
			ST_LOAD: phase_done = advance && last_idx;
			ST_DRAIN: phase_done = (drain_cnt == 2'(DRAIN_CYCLES - 1));
			default: phase_done = advance && walking && last_idx && half;
		endcase
	end

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			row <= '0;
			col <= '0;
			half <= 1'b0;
			stopped <= 1'b0;
			drain_cnt <= '0;
		end else begin
			if (phase == ST_DRAIN)
				drain_cnt <= drain_cnt + 2'd1;
			else
				drain_cnt <= '0;

			if (phase != ST_PASS2)
				stopped <= 1'b0;
			else if (phase_done)
				stopped <= 1'b1;

			if (advance) begin
				if (phase == ST_LOAD) begin
					col <= col + 3'd1;
					if (col == LAST_IDX)
						row <= row + 3'd1;
				end else if (walking) begin
					// Two halves per entry, columns inner, all indices wrap to zero
					half <= !half;
					if (half) begin
						col <= col + 3'd1;
						if (col == LAST_IDX)
							row <= row + 3'd1;
					end
				end
			end
		end
	end

	assign buf_if.rd_pass = (phase == ST_PASS2) ? PASS_COL : PASS_ROW;
	assign buf_if.rd_row = row;
	assign buf_if.rd_col = col;
	assign buf_if.rd_half = half;

	assign load_row = row;
	assign load_col = col;

	a_done_single: assert property (
		@(posedge Clock_50) disable iff (!resetn)
		phase_done |=> !phase_done
	) else $error("phase_done high on two consecutive cycles");

endmodule

/* idct_top.sv */
/*
  Top level of the 8x8 inverse DCT engine.
  Takes 64 coefficients on a valid/ready stream and returns 64 pixels row-major.
*/
`timescale 1ns/1ps

module idct_top import idct_pkg::*; #(
	parameter int ROW_SHIFT = ROW_SHIFT_DEF,
	parameter int COL_SHIFT = COL_SHIFT_DEF
) (
	input logic Clock_50,
	input logic resetn,
	input logic in_valid,
	output logic in_ready,
	input coef_t in_data,
	output logic out_valid,
	input logic out_ready,
	output pixel_t out_data
);

	ctrl_state_t phase;
	logic advance;
	logic phase_done;
	logic res_valid;
	idx_t load_row;
	idx_t load_col;

	idct_buf_if buf_if ();

	idct_ctrl u_ctrl (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.res_valid(res_valid),
		.phase_done(phase_done),
		.phase(phase),
		.advance(advance)
	);

	idct_step_counter u_counter (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.phase(phase),
		.advance(advance),
		.buf_if(buf_if.reader),
		.load_row(load_row),
		.load_col(load_col),
		.phase_done(phase_done)
	);

	// Coefficients are written on accepted beats only
	idct_block_buffer u_buffer (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.advance(advance),
		.in_valid_beat(in_valid & in_ready),
		.in_data(in_data),
		.load_row(load_row),
		.load_col(load_col),
		.buf_if(buf_if.store)
	);

	idct_mac #(
		.ROW_SHIFT(ROW_SHIFT),
		.COL_SHIFT(COL_SHIFT)
	) u_mac (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.advance(advance),
		.buf_if(buf_if.arith),
		.res_valid(res_valid),
		.out_data(out_data)
	);

endmodule

/* tb.f */
+incdir+.
idct_pkg.sv
idct_buf_if.sv
idct_ctrl.sv
idct_step_counter.sv
idct_block_buffer.sv
idct_mac.sv
idct_top.sv
tb_idct.sv

/* tb_idct_util.svh */
/*
  Testbench helpers for the IDCT engine: random source, reference model and value check.
  Included inside the testbench top module, after its parameters and failure task.
*/
`ifndef TB_IDCT_UTIL_SVH
`define TB_IDCT_UTIL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// Two passes from the definition: T = S'C then S = C'T, each with its own shift
function automatic void ref_idct(input coef_t s [BLOCK_WORDS], output pixel_t px [BLOCK_WORDS]);
	longint t [BLOCK_N][BLOCK_N];
	longint sum;
	longint v;
	for (int r = 0; r < BLOCK_N; r++) begin
		for (int c = 0; c < BLOCK_N; c++) begin
			sum = 0;
			for (int k = 0; k < BLOCK_N; k++)
				sum += longint'(s[r * BLOCK_N + k]) * longint'(IDCT_C[k][c]);
			t[r][c] = sum >>> ROW_SHIFT;
		end
	end
	for (int r = 0; r < BLOCK_N; r++) begin
		for (int c = 0; c < BLOCK_N; c++) begin
			sum = 0;
			for (int k = 0; k < BLOCK_N; k++)
				sum += longint'(IDCT_C[k][r]) * t[k][c];
			v = sum >>> COL_SHIFT;
			// Clip to the 8-bit pixel range
			if (v < 0)
				px[r * BLOCK_N + c] = 8'd0;
			else if (v > 255)
				px[r * BLOCK_N + c] = 8'd255;
			else
				px[r * BLOCK_N + c] = pixel_t'(v);
		end
	end
endfunction

// Compare a value against its expected value and stop on the first mismatch
task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s, got %0d, expected %0d", $time, what, got, exp);
		report_failure("Stopping at the first mismatch");
	end
endtask

`endif

/* tb_idct.sv */
/*
  Testbench for the 8x8 IDCT engine.
  Streams six blocks with random valid and ready gaps and checks every pixel
  against a reference model, plus the handshake rules of both streams.
*/
`timescale 1ns/1ps

module tb_idct import idct_pkg::*; ();

	localparam int ROW_SHIFT = ROW_SHIFT_DEF;
	localparam int COL_SHIFT = COL_SHIFT_DEF;
	localparam int NUM_BLOCKS = 6;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_WORDS * 4 + 2000;

	logic Clock_50;
	logic resetn;
	logic in_valid;
	logic in_ready;
	coef_t in_data;
	logic out_valid;
	logic out_ready;
	pixel_t out_data;

	logic [31:0] in_seed = 32'd5906;
	coef_t blk_coef [BLOCK_WORDS];
	pixel_t blk_px [BLOCK_WORDS];
	pixel_t exp_q [$];
	int blocks_loaded = 0;
	int blocks_done = 0;
	int pixels_seen = 0;
	int clip_hi = 0;
	int clip_lo = 0;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	`include "tb_idct_util.svh"

	idct_top #(
		.ROW_SHIFT(ROW_SHIFT),
		.COL_SHIFT(COL_SHIFT)
	) u_dut (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	initial begin
		Clock_50 = 1'b0;
		forever #5 Clock_50 = ~Clock_50;
	end

	function automatic coef_t rand_coef(input int span);
		in_seed = xorshift(in_seed);
		return coef_t'(int'(in_seed % 32'(2 * span + 1)) - span);
	endfunction

	// Block 0 is zero, 1 is a lone DC term, 4 and 5 push pixels past both clip limits
	task automatic make_block(input int kind);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			case (kind)
				0: blk_coef[i] = '0;
				1: blk_coef[i] = (i == 0) ? coef_t'(256) : coef_t'(0);
				4: blk_coef[i] = (i == 0) ? coef_t'(3000) : rand_coef(128);
				5: blk_coef[i] = (i == 0) ? coef_t'(-3000) : rand_coef(128);
				default: blk_coef[i] = rand_coef(512);
			endcase
		end
	endtask

	// A loaded block keeps the input closed until its last pixel is taken
	task automatic check_busy();
		if (blocks_loaded > blocks_done)
			check_val(in_ready, 0, "in_ready high while a block is in flight");
	endtask

	initial begin : stimulus
		int idx;
		resetn = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		repeat (5) @(posedge Clock_50);
		@(negedge Clock_50);
		resetn = 1'b1;
		@(negedge Clock_50);
		check_val(in_ready, 1, "in_ready after reset");
		check_val(out_valid, 0, "out_valid after reset");

		for (int b = 0; b < NUM_BLOCKS; b++) begin
			make_block(b);
			idx = 0;
			while (idx < BLOCK_WORDS) begin
				@(negedge Clock_50);
				check_busy();
				in_seed = xorshift(in_seed);
				in_valid = (in_seed[1:0] != 2'b00);
				in_data = blk_coef[idx];
				// in_ready cannot change before the coming rising edge
				if (in_valid && in_ready)
					idx++;
			end
			ref_idct(blk_coef, blk_px);
			for (int i = 0; i < BLOCK_WORDS; i++)
				exp_q.push_back(blk_px[i]);
			blocks_loaded++;
		end

		while (blocks_done < NUM_BLOCKS) begin
			@(negedge Clock_50);
			check_busy();
			in_valid = 1'b0;
		end
		repeat (4) @(negedge Clock_50);
		check_val(in_ready, 1, "in_ready after the last block");

		if (clip_hi == 0) begin
			report_failure("No pixel was clipped to 255 in the high clip block");
		end else if (clip_lo == 0) begin
			report_failure("No pixel was clipped to 0 in the low clip block");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	initial begin : compare
		logic [31:0] out_seed;
		logic stalled;
		pixel_t held;
		pixel_t exp_px;
		int blk;
		out_seed = xorshift(32'd5906);
		stalled = 1'b0;
		held = '0;
		wait (resetn === 1'b1);
		forever begin
			@(negedge Clock_50);
			if (stalled) begin
				check_val(out_valid, 1, "out_valid dropped during a stall");
				check_val(out_data, held, "out_data changed during a stall");
			end
			out_seed = xorshift(out_seed);
			out_ready = (out_seed[1:0] != 2'b00);
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0)
					report_failure("The DUT offered a pixel with no block pending");
				exp_px = exp_q.pop_front();
				blk = pixels_seen / BLOCK_WORDS;
				check_val(out_data, exp_px, $sformatf("pixel %0d of block %0d",
					pixels_seen % BLOCK_WORDS, blk));
				if (blk == 4 && out_data == 8'd255)
					clip_hi++;
				if (blk == 5 && out_data == 8'd0)
					clip_lo++;
				pixels_seen++;
				if (pixels_seen % BLOCK_WORDS == 0)
					blocks_done++;
			end
			stalled = out_valid && !out_ready;
			held = out_data;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge Clock_50);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				report_failure($sformatf("Timeout, the run did not end within %0d cycles",
					TIMEOUT_CYCLES));
		end
	end

endmodule
